//--- files.f
src/mbc_pkg.sv
src/rtc_pkg.sv
src/cart_bus_if.sv
src/mbc_bank_regs.sv
src/rtc_counter.sv
src/cart_ram.sv
src/cart_read_mux.sv
src/mbc3_cart.sv
verif/tb_mbc3_cart.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mbc3 cartridge testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_mbc3_cart -f files.f -o tb_mbc3_cart
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_mbc3_cart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- verif/tb_mbc3_cart.sv
`timescale 1ns/10ps

module tb_mbc3_cart;

   localparam int CLK_PERIOD = 4;
   localparam int TICKS      = 20;  // rtc prescaler length in cycles
   localparam int N_ROM      = 8;   // random rom banks tried
   localparam int N_RAM      = 8;   // bytes per ram bank
   localparam int WR_CYC     = 2;   // cycles per bus_write
   localparam int RD_CYC     = 4;   // cycles per bus_read incl. release
   // cycle budget summed over the tests
   localparam int TEST_CYCLES = 4 * RD_CYC + (N_ROM + 1) * (WR_CYC + 2 * RD_CYC)
                              + 4 * N_RAM * (2 * WR_CYC + 3 * RD_CYC) + 24 * WR_CYC
                              + 12 * (WR_CYC + RD_CYC) + 4 * TICKS;
   localparam int WATCHDOG_NS = (TEST_CYCLES + TEST_CYCLES / 2 + 100) * CLK_PERIOD;

   logic                             I_CLK = 1'b0;
   logic                             I_RESET;
   logic [mbc_pkg::ADDR_W-1:0]       cart_addr;
   logic [mbc_pkg::DATA_W-1:0]       cart_wdata;
   logic                             cart_we_n;
   logic                             cart_re_n;
   logic [mbc_pkg::DATA_W-1:0]       flash_data;
   logic [mbc_pkg::DATA_W-1:0]       cart_rdata;
   logic                             cart_rdata_oe;
   logic [mbc_pkg::FLASH_ADDR_W-1:0] flash_addr;

   logic [31:0]                  rng = 32'h535;  // xorshift state
   int                           n_checks = 0;
   int                           n_errors = 0;
   logic [12:0]                  ram_offs [N_RAM];   // same offsets in every bank
   logic [mbc_pkg::DATA_W-1:0]   ram_data [4][N_RAM];

   mbc3_cart #(
      .P_TICKS_PER_SEC (TICKS)
   ) DUT (
      .I_CLK         (I_CLK),
      .I_RESET       (I_RESET),
      .cart_addr     (cart_addr),
      .cart_wdata    (cart_wdata),
      .cart_we_n     (cart_we_n),
      .cart_re_n     (cart_re_n),
      .flash_data    (flash_data),
      .cart_rdata    (cart_rdata),
      .cart_rdata_oe (cart_rdata_oe),
      .flash_addr    (flash_addr)
   );

   always #(CLK_PERIOD / 2) I_CLK = ~I_CLK;

   // flash contents mix all 21 address bits
   function automatic logic [7:0] rom_byte(input logic [mbc_pkg::FLASH_ADDR_W-1:0] a);
      return a[7:0] ^ {a[13:8], a[20:19]} ^ {a[18:14], 3'b101} ^ 8'h5A;
   endfunction

   assign flash_data = rom_byte(flash_addr);  // combinational flash model

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_byte(input string name, input logic [mbc_pkg::DATA_W-1:0] got,
                             input logic [mbc_pkg::DATA_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %s: got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_flash_addr(input logic [mbc_pkg::FLASH_ADDR_W-1:0] got,
                                   input logic [mbc_pkg::FLASH_ADDR_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail flash_addr: got 0x%06h expected 0x%06h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // one strobe cycle that lands on the second edge
   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      @(posedge I_CLK);
      cart_addr  <= a;
      cart_wdata <= d;
      cart_we_n  <= 1'b0;
      @(posedge I_CLK);
      cart_we_n  <= 1'b1;
   endtask

   // strobe held for two edges then sampled mid cycle
   task automatic bus_read(input logic [15:0] a, output logic [7:0] d,
                           output logic [mbc_pkg::FLASH_ADDR_W-1:0] fa);
      @(posedge I_CLK);
      cart_addr <= a;
      cart_re_n <= 1'b0;
      repeat (2) @(posedge I_CLK);
      @(negedge I_CLK);
      d  = cart_rdata;
      fa = flash_addr;
      check_bit("cart_rdata_oe", cart_rdata_oe, 1'b1);  // oe follows strobe
      @(posedge I_CLK);
      cart_re_n <= 1'b1;
   endtask

   task automatic rom_read_check(input logic [15:0] a, input logic [6:0] bank);
      logic [7:0]                       d;
      logic [mbc_pkg::FLASH_ADDR_W-1:0] fa;
      logic [mbc_pkg::FLASH_ADDR_W-1:0] fa_exp;
      fa_exp = {bank, a[13:0]};  // bank above 14-bit offset
      bus_read(a, d, fa);
      check_flash_addr(fa, fa_exp);
      check_byte("cart_rdata rom", d, rom_byte(fa_exp));
   endtask

   task automatic read_check(input logic [15:0] a, input logic [7:0] exp, input string name);
      logic [7:0]                       d;
      logic [mbc_pkg::FLASH_ADDR_W-1:0] fa;
      bus_read(a, d, fa);
      check_byte(name, d, exp);
   endtask

   task automatic rtc_write(input logic [3:0] sel, input logic [7:0] v);
      bus_write(16'h4000, {4'h0, sel});  // rtc select via ram bank
      bus_write(16'hA000, v);
   endtask

   task automatic rtc_read_check(input logic [3:0] sel, input logic [7:0] exp);
      bus_write(16'h4000, {4'h0, sel});
      read_check(16'hA000, exp, "cart_rdata rtc");
   endtask

   task automatic ram_readback();
      for (int b = 0; b < 4; b++) begin
         bus_write(16'h5000, 8'(b));
         for (int j = 0; j < N_RAM; j++) begin
            read_check({3'b101, ram_offs[j]}, ram_data[b][j], "cart_rdata ram");
         end
      end
   endtask

   task automatic test_reset_state();
      @(negedge I_CLK);
      check_bit("cart_rdata_oe", cart_rdata_oe, 1'b0);  // strobe idle
      rom_read_check(16'h4000, 7'd1);                   // reset bank is 1
      read_check(16'hA000, 8'h00, "cart_rdata ram off");
      @(negedge I_CLK);
      check_bit("cart_rdata_oe", cart_rdata_oe, 1'b0);
   endtask

   task automatic test_rom_banking();
      logic [6:0] exp_bank;
      for (int i = 0; i < N_ROM; i++) begin
         rng = xorshift32(rng);
         exp_bank = (rng[6:0] == 7'd0) ? 7'd1 : rng[6:0];  // low 7 bits with 0 read as 1
         bus_write({3'b001, rng[20:8]}, rng[7:0]);
         rom_read_check({2'b01, rng[29:16]}, exp_bank);  // switchable window
         rom_read_check({2'b00, rng[13:0]}, 7'd0);       // fixed window
      end
      bus_write(16'h3FFF, 8'h00);
      rom_read_check(16'h7FFF, 7'd1);
   endtask

   task automatic test_ram_banks();
      for (int j = 0; j < N_RAM; j++) begin
         rng = xorshift32(rng);
         ram_offs[j] = {3'(j), rng[9:0]};  // distinct per j
      end
      bus_write(16'h0000, 8'h0A);  // ram on
      for (int b = 0; b < 4; b++) begin
         bus_write(16'h4000, 8'(b));
         for (int j = 0; j < N_RAM; j++) begin
            rng = xorshift32(rng);
            ram_data[b][j] = rng[7:0];
            bus_write({3'b101, ram_offs[j]}, ram_data[b][j]);
         end
      end
      ram_readback();  // banks must not alias
      bus_write(16'h1FFF, 8'h00);  // ram off
      for (int b = 0; b < 4; b++) begin
         bus_write(16'h4000, 8'(b));
         for (int j = 0; j < N_RAM; j++) begin
            read_check({3'b101, ram_offs[j]}, 8'h00, "cart_rdata ram off");
            bus_write({3'b101, ram_offs[j]}, ~ram_data[b][j]);  // dropped
         end
      end
      bus_write(16'h0ABC, 8'h0A);
      ram_readback();
   endtask

   task automatic test_rtc_regs();
      logic [7:0] vals [5];
      rng = xorshift32(rng);
      vals[0] = 8'(rng[15:8] % 60);
      vals[1] = 8'(rng[23:16] % 60);
      vals[2] = 8'(rng[28:24] % 24);
      vals[3] = rng[31:24];
      vals[4] = {rng[0], 1'b1, 5'b0, rng[1]};  // carry, halt, day bit 8
      bus_write(16'h0000, 8'h0A);
      rtc_write(4'd12, vals[4]);  // halt before loading time
      for (int r = 0; r < 4; r++) begin
         rtc_write(4'(8 + r), vals[r]);
      end
      for (int r = 0; r < 5; r++) begin
         rtc_read_check(4'(8 + r), vals[r]);
      end
      for (int b = 4; b < 8; b++) begin
         bus_write(16'h4000, 8'(b));
         // offset that holds data in ram bank b-4
         read_check({3'b101, ram_offs[b - 4]}, 8'h00, "cart_rdata unmapped bank");
      end
   endtask

   task automatic test_rtc_latch();
      logic [7:0]                       d;
      logic [mbc_pkg::FLASH_ADDR_W-1:0] fa;
      rtc_write(4'd12, 8'h41);  // halted with day bit 8 set
      rtc_write(4'd8, 8'd59);
      rtc_write(4'd9, 8'd59);
      rtc_write(4'd10, 8'd23);
      rtc_write(4'd11, 8'hFF);  // day 511
      rtc_write(4'd12, 8'h01);  // halt off so counting starts
      repeat (TICKS + TICKS / 4) @(posedge I_CLK);  // past one second but short of two
      bus_write(16'h6000, 8'h00);
      bus_write(16'h7FFF, 8'h01);
      rtc_read_check(4'd8, 8'h00);
      rtc_read_check(4'd9, 8'h00);
      rtc_read_check(4'd10, 8'h00);
      rtc_read_check(4'd11, 8'h00);
      rtc_read_check(4'd12, 8'h80);  // day wrapped so only carry
      repeat (2 * TICKS) @(posedge I_CLK);  // live seconds move on
      bus_write(16'h6000, 8'h01);           // lone 01
      rtc_read_check(4'd8, 8'h00);
      bus_write(16'h6000, 8'h00);
      bus_write(16'h4000, 8'd8);            // other region in between
      bus_write(16'h6000, 8'h01);
      bus_read(16'hA000, d, fa);
      n_checks++;
      if (d == 8'h00) begin
         n_errors++;
         $display("Error: latched seconds did not advance after 00, other write, 01");
      end
   endtask

   initial begin
      I_RESET    = 1'b1;
      cart_addr  = '0;
      cart_wdata = '0;
      cart_we_n  = 1'b1;
      cart_re_n  = 1'b1;
      repeat (2) @(posedge I_CLK);
      I_RESET <= 1'b0;
      test_reset_state();
      test_rom_banking();
      test_ram_banks();
      test_rtc_regs();
      test_rtc_latch();
      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // hard stop if a test hangs
   initial begin
      #(WATCHDOG_NS);
      $display("Error: timeout after %0d ns, tests did not finish (%0d errors so far)",
               WATCHDOG_NS, n_errors);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- src/mbc3_cart.sv
`timescale 1ns/10ps

module mbc3_cart #(
   parameter int unsigned P_TICKS_PER_SEC = rtc_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                             I_CLK,
   input  logic                             I_RESET,
   input  logic [mbc_pkg::ADDR_W-1:0]       cart_addr,
   input  logic [mbc_pkg::DATA_W-1:0]       cart_wdata,
   input  logic                             cart_we_n,
   input  logic                             cart_re_n,
   input  logic [mbc_pkg::DATA_W-1:0]       flash_data,
   output logic [mbc_pkg::DATA_W-1:0]       cart_rdata,
   output logic                             cart_rdata_oe,   // drive the data pins
   output logic [mbc_pkg::FLASH_ADDR_W-1:0] flash_addr
);

   cart_bus_if bus ();

   mbc_pkg::mbc_state_t              state;
   logic                             latch;
   rtc_pkg::rtc_time_t               rtc_latched;
   logic                             ram_we;
   logic [mbc_pkg::RAM_ADDR_W-1:0]   ram_addr;
   logic [mbc_pkg::DATA_W-1:0]       ram_rdata;

   // pins are active low, internal strobes active high
   assign bus.addr      = cart_addr;
   assign bus.wdata     = cart_wdata;
   assign bus.we        = ~cart_we_n;
   assign bus.re        = ~cart_re_n;
   assign cart_rdata_oe = bus.re;

   mbc_bank_regs u_bank_regs (
      .I_CLK   (I_CLK),
      .I_RESET (I_RESET),
      .bus     (bus),
      .state   (state),
      .latch   (latch)
   );

   rtc_counter #(
      .P_TICKS_PER_SEC (P_TICKS_PER_SEC)
   ) u_rtc (
      .I_CLK   (I_CLK),
      .I_RESET (I_RESET),
      .bus     (bus),
      .state   (state),
      .latch   (latch),
      .rtc     (rtc_latched)
   );

   cart_ram u_ram (
      .I_CLK (I_CLK),
      .we    (ram_we),
      .addr  (ram_addr),
      .wdata (bus.wdata),
      .rdata (ram_rdata)
   );

   cart_read_mux u_read_mux (
      .bus        (bus),
      .state      (state),
      .rtc        (rtc_latched),
      .flash_data (flash_data),
      .ram_rdata  (ram_rdata),
      .flash_addr (flash_addr),
      .ram_we     (ram_we),
      .ram_addr   (ram_addr),
      .rdata      (cart_rdata)
   );

endmodule

//--- src/cart_read_mux.sv
`timescale 1ns/10ps

module cart_read_mux (
   cart_bus_if.rd                           bus,
   input  mbc_pkg::mbc_state_t              state,
   input  rtc_pkg::rtc_time_t               rtc,
   input  logic [mbc_pkg::DATA_W-1:0]       flash_data,
   input  logic [mbc_pkg::DATA_W-1:0]       ram_rdata,
   output logic [mbc_pkg::FLASH_ADDR_W-1:0] flash_addr,
   output logic                             ram_we,
   output logic [mbc_pkg::RAM_ADDR_W-1:0]   ram_addr,
   output logic [mbc_pkg::DATA_W-1:0]       rdata
);

   logic                       in_rom, in_fixed, in_ram;
   logic                       bank_is_ram;   // ram bank 0..3
   logic                       bank_is_rtc;   // rtc select 8..12
   logic [mbc_pkg::DATA_W-1:0] rtc_byte;

   assign in_rom   = bus.addr <= mbc_pkg::ROM_END;
   assign in_fixed = bus.addr <= mbc_pkg::ROM_FIXED_END;
   assign in_ram   = (bus.addr >= mbc_pkg::RAM_BASE) && (bus.addr <= mbc_pkg::RAM_END);

   assign bank_is_ram = state.ram_bank <= mbc_pkg::RAM_BANK_LAST;
   assign bank_is_rtc = (state.ram_bank >= rtc_pkg::RTC_SEL_SEC)
                     && (state.ram_bank <= rtc_pkg::RTC_SEL_DH);

   // banks stored back to back in flash, fixed window is always bank 0
   assign flash_addr = {in_fixed ? '0 : state.rom_bank, bus.addr[mbc_pkg::ROM_OFFSET_W-1:0]};

   // a000 is 8K aligned so the low bits are already the offset
   assign ram_addr = {state.ram_bank[mbc_pkg::RAM_BANK_SEL_W-1:0],
                      bus.addr[mbc_pkg::RAM_OFFSET_W-1:0]};
   assign ram_we   = bus.we && in_ram && state.ram_en && bank_is_ram;

   always_comb begin
      rtc_byte = '0;
      case (state.ram_bank)
         rtc_pkg::RTC_SEL_SEC:  rtc_byte = rtc.sec;
         rtc_pkg::RTC_SEL_MIN:  rtc_byte = rtc.min;
         rtc_pkg::RTC_SEL_HOUR: rtc_byte = rtc.hour;
         rtc_pkg::RTC_SEL_DL:   rtc_byte = rtc.day[7:0];
         rtc_pkg::RTC_SEL_DH: begin
            rtc_byte[rtc_pkg::DH_DAY8_BIT]  = rtc.day[8];
            rtc_byte[rtc_pkg::DH_HALT_BIT]  = rtc.halt;
            rtc_byte[rtc_pkg::DH_CARRY_BIT] = rtc.carry;
         end
         default: rtc_byte = '0;
      endcase
   end

   // 00 when idle, like a released bus
   always_comb begin
      rdata = '0;
      if (bus.re) begin
         if (in_rom) begin
            rdata = flash_data;
         end else if (in_ram && state.ram_en) begin
            if (bank_is_ram) begin
               rdata = ram_rdata;
            end else if (bank_is_rtc) begin
               rdata = rtc_byte;
            end  // banks 4-7 and 13-15 unmapped
         end
      end
   end

endmodule

//--- src/cart_ram.sv
`timescale 1ns/10ps

module cart_ram (
   input  logic                           I_CLK,
   input  logic                           we,
   input  logic [mbc_pkg::RAM_ADDR_W-1:0] addr,   // {bank, offset}
   input  logic [mbc_pkg::DATA_W-1:0]     wdata,
   output logic [mbc_pkg::DATA_W-1:0]     rdata
);

   // 4 x 8 KiB, maps to block ram
   logic [mbc_pkg::DATA_W-1:0] mem [2**mbc_pkg::RAM_ADDR_W];

   always_ff @(posedge I_CLK) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // one cycle read latency, old data on a write
   end

endmodule

//--- src/rtc_counter.sv
`timescale 1ns/10ps

module rtc_counter #(
   parameter int unsigned P_TICKS_PER_SEC = rtc_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                I_CLK,
   input  logic                I_RESET,
   cart_bus_if.ctrl            bus,
   input  mbc_pkg::mbc_state_t state,
   input  logic                latch,
   output rtc_pkg::rtc_time_t  rtc
);

   logic [31:0]        presc;    // cycles into the current second
   logic               tick;     // one second elapsed
   logic               rtc_wr;   // cpu write to an rtc register
   rtc_pkg::rtc_time_t live;     // running clock
   rtc_pkg::rtc_time_t latched;  // snapshot the cpu reads

   assign tick = !live.halt && (presc == 32'(P_TICKS_PER_SEC - 1));

   // rtc regs live in the ram window when bank is 8..12
   assign rtc_wr = bus.we && state.ram_en
                && (bus.addr >= mbc_pkg::RAM_BASE) && (bus.addr <= mbc_pkg::RAM_END)
                && (state.ram_bank >= rtc_pkg::RTC_SEL_SEC)
                && (state.ram_bank <= rtc_pkg::RTC_SEL_DH);

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         presc   <= '0;
         live    <= '0;
         latched <= '0;
      end else begin
         if (!live.halt) begin
            presc <= tick ? '0 : presc + 32'd1;  // frozen while halted
         end

         // seconds -> minutes -> hours -> days ripple
         if (tick) begin
            if (live.sec == rtc_pkg::SEC_LAST) begin
               live.sec <= '0;
               if (live.min == rtc_pkg::MIN_LAST) begin
                  live.min <= '0;
                  if (live.hour == rtc_pkg::HOUR_LAST) begin
                     live.hour <= '0;
                     if (live.day == rtc_pkg::DAY_LAST) begin
                        live.day   <= '0;
                        live.carry <= 1'b1;  // sticky, only cpu clears it
                     end else begin
                        live.day <= live.day + 9'd1;
                     end
                  end else begin
                     live.hour <= live.hour + 8'd1;
                  end
               end else begin
                  live.min <= live.min + 8'd1;
               end
            end else begin
               live.sec <= live.sec + 8'd1;
            end
         end

         if (latch) begin
            latched <= live;  // snapshot on 00/01 sequence
         end

         // cpu writes go to both copies, and win over the tick
         if (rtc_wr) begin
            case (state.ram_bank)
               rtc_pkg::RTC_SEL_SEC: begin
                  live.sec    <= bus.wdata;
                  latched.sec <= bus.wdata;
                  presc       <= '0;  // restart the second
               end
               rtc_pkg::RTC_SEL_MIN: begin
                  live.min    <= bus.wdata;
                  latched.min <= bus.wdata;
               end
               rtc_pkg::RTC_SEL_HOUR: begin
                  live.hour    <= bus.wdata;
                  latched.hour <= bus.wdata;
               end
               rtc_pkg::RTC_SEL_DL: begin
                  live.day[7:0]    <= bus.wdata;
                  latched.day[7:0] <= bus.wdata;
               end
               default: begin  // day high
                  live.day[8]    <= bus.wdata[rtc_pkg::DH_DAY8_BIT];
                  live.halt      <= bus.wdata[rtc_pkg::DH_HALT_BIT];
                  live.carry     <= bus.wdata[rtc_pkg::DH_CARRY_BIT];
                  latched.day[8] <= bus.wdata[rtc_pkg::DH_DAY8_BIT];
                  latched.halt   <= bus.wdata[rtc_pkg::DH_HALT_BIT];
                  latched.carry  <= bus.wdata[rtc_pkg::DH_CARRY_BIT];
               end
            endcase
         end
      end
   end

   assign rtc = latched;

endmodule

//--- src/mbc_bank_regs.sv
`timescale 1ns/10ps

module mbc_bank_regs (
   input  logic                I_CLK,
   input  logic                I_RESET,
   cart_bus_if.ctrl            bus,
   output mbc_pkg::mbc_state_t state,
   output logic                latch
);

   logic                                ctrl_wr;    // write lands in a control reg
   logic                                zero_seen;  // latch seq armed
   logic [mbc_pkg::ROM_BANK_W-1:0]      bank_in;    // raw rom bank from data

   // any write into rom space is a register write, rom itself is read only
   assign ctrl_wr = bus.we && (bus.addr <= mbc_pkg::ROM_END);
   assign bank_in = bus.wdata[mbc_pkg::ROM_BANK_W-1:0];

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         state.ram_en   <= 1'b0;
         state.rom_bank <= mbc_pkg::ROM_BANK_RESET;
         state.ram_bank <= '0;
         zero_seen      <= 1'b0;
         latch          <= 1'b0;
      end else begin
         latch <= 1'b0;  // pulse only

         if (ctrl_wr) begin
            case (bus.addr[15:12])
               // 0000-1fff ram/timer enable
               4'h0, 4'h1: begin
                  if (bus.wdata == mbc_pkg::RAM_ENABLE_KEY) begin
                     state.ram_en <= 1'b1;
                  end else if (bus.wdata == mbc_pkg::RAM_DISABLE_KEY) begin
                     state.ram_en <= 1'b0;
                  end  // other values keep the old setting
               end

               // 2000-3fff rom bank
               4'h2, 4'h3: begin
                  // bank 0 already sits in the fixed half so 0 means 1
                  state.rom_bank <= (bank_in == '0) ? mbc_pkg::ROM_BANK_RESET : bank_in;
               end

               // 4000-5fff ram bank or rtc register select
               4'h4, 4'h5: begin
                  state.ram_bank <= bus.wdata[mbc_pkg::RAM_BANK_W-1:0];
               end

               // 6000-7fff clock latch, 00 then 01
               default: begin
                  if (bus.wdata == mbc_pkg::LATCH_ARM) begin
                     zero_seen <= 1'b1;
                  end else if (zero_seen && bus.wdata == mbc_pkg::LATCH_FIRE) begin
                     latch     <= 1'b1;
                     zero_seen <= 1'b0;
                  end else begin
                     zero_seen <= 1'b0;  // any other value breaks the seq
                  end
               end
            endcase
         end
      end
   end

endmodule

//--- src/cart_bus_if.sv
`timescale 1ns/10ps

interface cart_bus_if;

   logic [mbc_pkg::ADDR_W-1:0] addr;   // cpu address
   logic [mbc_pkg::DATA_W-1:0] wdata;  // cpu write byte
   logic                       we;     // one cycle per write strobe
   logic                       re;     // level, held for the whole read

   // top level drives everything from the pins
   modport master (
      output addr,
      output wdata,
      output we,
      output re
   );

   // register writers
   modport ctrl (
      input addr,
      input wdata,
      input we
   );

   // decode and read side
   modport rd (
      input addr,
      input we,
      input re
   );

endinterface

//--- src/rtc_pkg.sv
package rtc_pkg;

   // ram bank codes that map an rtc register into a000-bfff
   localparam logic [3:0] RTC_SEL_SEC  = 4'd8;
   localparam logic [3:0] RTC_SEL_MIN  = 4'd9;
   localparam logic [3:0] RTC_SEL_HOUR = 4'd10;
   localparam logic [3:0] RTC_SEL_DL   = 4'd11;   // day low byte
   localparam logic [3:0] RTC_SEL_DH   = 4'd12;   // day high, halt, carry

   // day-high register layout
   localparam int DH_DAY8_BIT  = 0;
   localparam int DH_HALT_BIT  = 6;
   localparam int DH_CARRY_BIT = 7;

   // rollover points
   localparam logic [7:0] SEC_LAST  = 8'd59;
   localparam logic [7:0] MIN_LAST  = 8'd59;
   localparam logic [7:0] HOUR_LAST = 8'd23;
   localparam logic [8:0] DAY_LAST  = 9'd511;

   localparam int unsigned TICKS_PER_SEC_DEFAULT = 33_000_000;  // 33 MHz clock

   typedef struct packed {
      logic [7:0] sec;
      logic [7:0] min;
      logic [7:0] hour;
      logic [8:0] day;
      logic       halt;   // stops the prescaler
      logic       carry;  // day counter overflowed
   } rtc_time_t;

endpackage

//--- src/mbc_pkg.sv
package mbc_pkg;

   // bus widths
   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 8;

   // bank geometry
   localparam int ROM_BANK_W     = 7;   // up to 128 rom banks
   localparam int RAM_BANK_W     = 4;   // also reaches the rtc selects 8..12
   localparam int RAM_BANK_SEL_W = 2;   // four real ram banks
   localparam int ROM_OFFSET_W   = 14;  // 16 KiB per rom bank
   localparam int RAM_OFFSET_W   = 13;  // 8 KiB per ram bank
   localparam int FLASH_ADDR_W   = ROM_BANK_W + ROM_OFFSET_W;      // 21
   localparam int RAM_ADDR_W     = RAM_BANK_SEL_W + RAM_OFFSET_W;  // 15

   // cpu address map
   localparam logic [ADDR_W-1:0] ROM_FIXED_END = 16'h3FFF;  // bank 0 window
   localparam logic [ADDR_W-1:0] ROM_END       = 16'h7FFF;  // top of switchable window
   localparam logic [ADDR_W-1:0] RAM_BASE      = 16'hA000;
   localparam logic [ADDR_W-1:0] RAM_END       = 16'hBFFF;

   // control register values
   localparam logic [DATA_W-1:0] RAM_ENABLE_KEY  = 8'h0A;
   localparam logic [DATA_W-1:0] RAM_DISABLE_KEY = 8'h00;
   localparam logic [DATA_W-1:0] LATCH_ARM       = 8'h00;  // first write of latch seq
   localparam logic [DATA_W-1:0] LATCH_FIRE      = 8'h01;  // second write

   localparam logic [RAM_BANK_W-1:0] RAM_BANK_LAST  = 4'd3;
   localparam logic [ROM_BANK_W-1:0] ROM_BANK_RESET = 7'd1;  // bank 0 never in upper half

   // banking state shared by the whole controller
   typedef struct packed {
      logic                  ram_en;    // ram and timer access
      logic [ROM_BANK_W-1:0] rom_bank;  // bank seen at 4000-7fff
      logic [RAM_BANK_W-1:0] ram_bank;  // 0-3 ram, 8-12 rtc
   } mbc_state_t;

endpackage
